//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = radar_display_tb
FILELIST = files.f
BUILD    = obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove $(BUILD)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

//--- files.f
source/radar_pkg.sv
source/raster_scan.sv
source/coord_map.sv
source/grid_render.sv
source/target_mark.sv
source/radar_display_top.sv
verif/tb_clock_gen.sv
verif/radar_display_sva.sv
verif/radar_display_tb.sv

//--- source/coord_map.sv
`timescale 1ns/1ps

module coord_map import radar_pkg::*; #(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480
) (
	input  logic        clk,
	input  logic        arst_n,
	input  count_t      hcount,
	input  count_t      vcount,
	input  video_sync_t sync_in,
	output coord_px_t   px
);

	// x origin at the middle of the line
	localparam coord_t X_CENTER = coord_t'(H_ACTIVE / 2);
	// bottom visible row maps to y = 0
	localparam coord_t Y_TOP    = coord_t'(V_ACTIVE - 1);

	video_sync_t sync_q;
	coord_t      x_q;
	coord_t      y_q;

	// sync side of the stage
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= SYNC_IDLE;
		end else begin
			sync_q <= sync_in;
		end
	end

	// coordinates, zero extend the counts before going signed
	always_ff @(posedge clk) begin
		x_q <= $signed({1'b0, hcount}) - X_CENTER;
		// flip vertically so y grows toward the top of the screen
		y_q <= Y_TOP - $signed({1'b0, vcount});
	end

	assign px = '{sync: sync_q, x: x_q, y: y_q};

endmodule

//--- source/grid_render.sv
`timescale 1ns/1ps

module grid_render import radar_pkg::*; #(
	parameter int LEFT_BORDER   = -240,
	parameter int RIGHT_BORDER  = 240,
	parameter int TOP_BORDER    = 460,
	parameter int BOTTOM_BORDER = 16,
	parameter int LINE_WIDTH    = 1
) (
	input  logic      clk,
	input  logic      arst_n,
	input  coord_px_t px_in,
	output grid_px_t  px_out
);

	////////////////////////////////////////////////////////////
	// geometry constants
	////////////////////////////////////////////////////////////

	// frame extends this far outside the border lines
	localparam int BORDER_WIDTH = 3;

	localparam coord_t X_LEFT   = coord_t'(LEFT_BORDER);
	localparam coord_t X_RIGHT  = coord_t'(RIGHT_BORDER);
	localparam coord_t Y_TOP    = coord_t'(TOP_BORDER);
	localparam coord_t Y_BOTTOM = coord_t'(BOTTOM_BORDER);
	localparam coord_t X_LEFT_OUT   = coord_t'(LEFT_BORDER - BORDER_WIDTH);
	localparam coord_t X_RIGHT_OUT  = coord_t'(RIGHT_BORDER + BORDER_WIDTH);
	localparam coord_t Y_TOP_OUT    = coord_t'(TOP_BORDER + BORDER_WIDTH);
	localparam coord_t Y_BOTTOM_OUT = coord_t'(BOTTOM_BORDER - BORDER_WIDTH);

	// arc tolerance on d^2 widens with radius, else outer arcs break up
	localparam int ROUND_1 = 64;
	localparam int ROUND_2 = 128;
	localparam int ROUND_4 = 256;

	localparam dist_t ARC_RADIUS_SQ [0:6] = '{
		dist_t'(32 * 32), dist_t'(64 * 64), dist_t'(96 * 96), dist_t'(128 * 128),
		dist_t'(160 * 160), dist_t'(192 * 192), dist_t'(224 * 224)
	};
	localparam int ARC_ROUNDING [0:6] = '{
		ROUND_1, ROUND_2, ROUND_2, ROUND_2, ROUND_4, ROUND_4, ROUND_4
	};

	// tan 15 ~ 17/64, tan 75 ~ 240/64, tan 45 is exact
	localparam int TAN15_NUM = 17;
	localparam int TAN75_NUM = 240;
	localparam int TAN_SHIFT = 6;

	// steep lines need a wider window in y
	localparam int RADIAL_ROUND = 3;

	localparam dist_t LINE_HALF  = dist_t'(LINE_WIDTH);
	localparam dist_t STEEP_HALF = dist_t'(LINE_WIDTH * RADIAL_ROUND);

	// true when delta lies in [-half, half]
	function automatic logic within_window(input dist_t delta, input dist_t half);
		return (delta >= -half) && (delta <= half);
	endfunction

	////////////////////////////////////////////////////////////
	// grid detection
	////////////////////////////////////////////////////////////

	logic  on_border;
	logic  out_of_border;
	logic  on_arc;
	logic  on_radial;
	logic  on_grid_d;
	dist_t x_wide;
	dist_t y_eff;
	dist_t dist_sq;
	dist_t tan15;
	dist_t tan45;
	dist_t tan75;

	always_comb begin
		// frame band and the region past it
		on_border = (px_in.x >= X_RIGHT) || (px_in.x <= X_LEFT) ||
			(px_in.y >= Y_TOP) || (px_in.y <= Y_BOTTOM);
		out_of_border = (px_in.x > X_RIGHT_OUT) || (px_in.x < X_LEFT_OUT) ||
			(px_in.y > Y_TOP_OUT) || (px_in.y < Y_BOTTOM_OUT);

		// polar origin sits on the bottom border at x = 0
		x_wide  = dist_t'(px_in.x);
		y_eff   = dist_t'(px_in.y) - dist_t'(BOTTOM_BORDER);
		dist_sq = (x_wide * x_wide) + (y_eff * y_eff);

		on_arc = 1'b0;
		for (int i = 0; i < 7; i++) begin
			on_arc = on_arc | within_window(dist_sq - ARC_RADIUS_SQ[i],
				dist_t'(LINE_WIDTH * ARC_ROUNDING[i]));
		end

		// y of each line at this x, arithmetic shift keeps the sign
		tan15 = (x_wide * dist_t'(TAN15_NUM)) >>> TAN_SHIFT;
		tan45 = x_wide;
		tan75 = (x_wide * dist_t'(TAN75_NUM)) >>> TAN_SHIFT;

		// minus y for 15/45/75, plus y for the mirrored 165/135/105
		on_radial = within_window(tan15 - y_eff, LINE_HALF) |
			within_window(tan15 + y_eff, LINE_HALF) |
			within_window(tan45 - y_eff, LINE_HALF) |
			within_window(tan45 + y_eff, LINE_HALF) |
			within_window(tan75 - y_eff, STEEP_HALF) |
			within_window(tan75 + y_eff, STEEP_HALF);

		// nothing is drawn during blank or past the frame
		on_grid_d = !px_in.sync.blank && !out_of_border &&
			(on_border || on_arc || on_radial);
	end

	////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////

	video_sync_t sync_q;
	logic        on_grid_q;
	coord_t      x_q;
	coord_t      y_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_q    <= SYNC_IDLE;
			on_grid_q <= 1'b0;
		end else begin
			sync_q    <= px_in.sync;
			on_grid_q <= on_grid_d;
		end
	end

	// coordinates ride along for the target stage
	always_ff @(posedge clk) begin
		x_q <= px_in.x;
		y_q <= px_in.y;
	end

	assign px_out = '{sync: sync_q, x: x_q, y: y_q, on_grid: on_grid_q};

endmodule

//--- source/radar_display_top.sv
`timescale 1ns/1ps

module radar_display_top import radar_pkg::*; #(
	// raster timing
	parameter int     H_ACTIVE      = 640,
	parameter int     H_FRONT       = 16,
	parameter int     H_SYNC        = 96,
	parameter int     H_BACK        = 48,
	parameter int     V_ACTIVE      = 480,
	parameter int     V_FRONT       = 10,
	parameter int     V_SYNC        = 2,
	parameter int     V_BACK        = 33,
	// grid geometry in display coordinates
	parameter int     LEFT_BORDER   = -240,
	parameter int     RIGHT_BORDER  = 240,
	parameter int     TOP_BORDER    = 460,
	parameter int     BOTTOM_BORDER = 16,
	parameter int     LINE_WIDTH    = 1,
	// colours and marker size
	parameter color_t GRID_COLOR    = 24'hFF_00_00,
	parameter color_t BLANK_COLOR   = 24'h00_00_00,
	parameter color_t TARGET_COLOR  = 24'h00_FF_00,
	parameter int     TARGET_HALF   = 2
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       target_load,
	input  logic       target_clear,
	input  coord_t     target_x,
	input  coord_t     target_y,
	output video_out_t video
);

	count_t      hcount;
	count_t      vcount;
	video_sync_t scan_sync;
	coord_px_t   coord_px;
	grid_px_t    grid_px;

	////////////////////////////////////////////////////////////
	// scan -> coords -> grid -> target, one register per stage
	////////////////////////////////////////////////////////////

	raster_scan #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) raster_scan_inst (
		.clk(clk), .arst_n(arst_n), .hcount(hcount), .vcount(vcount), .sync(scan_sync)
	);

	coord_map #(
		.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
	) coord_map_inst (
		.clk(clk), .arst_n(arst_n), .hcount(hcount), .vcount(vcount),
		.sync_in(scan_sync), .px(coord_px)
	);

	grid_render #(
		.LEFT_BORDER(LEFT_BORDER), .RIGHT_BORDER(RIGHT_BORDER),
		.TOP_BORDER(TOP_BORDER), .BOTTOM_BORDER(BOTTOM_BORDER), .LINE_WIDTH(LINE_WIDTH)
	) grid_render_inst (
		.clk(clk), .arst_n(arst_n), .px_in(coord_px), .px_out(grid_px)
	);

	target_mark #(
		.GRID_COLOR(GRID_COLOR), .BLANK_COLOR(BLANK_COLOR),
		.TARGET_COLOR(TARGET_COLOR), .TARGET_HALF(TARGET_HALF)
	) target_mark_inst (
		.clk(clk), .arst_n(arst_n), .target_load(target_load), .target_clear(target_clear),
		.target_x(target_x), .target_y(target_y), .px_in(grid_px), .video(video)
	);

endmodule

//--- source/radar_pkg.sv
package radar_pkg;

	////////////////////////////////////////////////////////////
	// scalar types
	////////////////////////////////////////////////////////////

	// unsigned raster counter, wide enough for any line or frame total
	typedef logic [10:0] count_t;

	// signed display coordinate, x centred and y counting upward
	typedef logic signed [11:0] coord_t;

	// signed squared distance and wide intermediate products
	typedef logic signed [31:0] dist_t;

	// rgb colour, 8 bits per channel, red in the top byte
	typedef logic [23:0] color_t;

	////////////////////////////////////////////////////////////
	// pixel bundles
	////////////////////////////////////////////////////////////

	// sync and blank, delayed together with every pixel
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic blank;
	} video_sync_t;

	// output of coord_map
	typedef struct packed {
		video_sync_t sync;
		coord_t      x;
		coord_t      y;
	} coord_px_t;

	// output of grid_render
	typedef struct packed {
		video_sync_t sync;
		coord_t      x;
		coord_t      y;
		logic        on_grid;
	} grid_px_t;

	// final video output
	typedef struct packed {
		video_sync_t sync;
		color_t      pixel;
	} video_out_t;

	// syncs inactive high, blank asserted
	localparam video_sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, blank: 1'b1};

endpackage

//--- source/raster_scan.sv
`timescale 1ns/1ps

module raster_scan import radar_pkg::*; #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  logic        clk,
	input  logic        arst_n,
	output count_t      hcount,
	output count_t      vcount,
	output video_sync_t sync
);

	// last count of a line and of a frame
	localparam count_t H_LAST = count_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
	localparam count_t V_LAST = count_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

	// sync windows sit right after the front porch
	localparam count_t H_SYNC_START = count_t'(H_ACTIVE + H_FRONT);
	localparam count_t H_SYNC_END   = count_t'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam count_t V_SYNC_START = count_t'(V_ACTIVE + V_FRONT);
	localparam count_t V_SYNC_END   = count_t'(V_ACTIVE + V_FRONT + V_SYNC);

	// edge of the active area
	localparam count_t H_VISIBLE = count_t'(H_ACTIVE);
	localparam count_t V_VISIBLE = count_t'(V_ACTIVE);

	logic   line_end;
	logic   frame_end;
	count_t h_next;
	count_t v_next;

	// next raster position
	always_comb begin
		line_end  = (hcount == H_LAST);
		frame_end = (vcount == V_LAST);
		h_next    = line_end ? '0 : hcount + count_t'(1);
		if (line_end) begin
			// vertical count only steps at the end of a line
			v_next = frame_end ? '0 : vcount + count_t'(1);
		end else begin
			v_next = vcount;
		end
	end

	// counters and syncs are registered from the same next position
	// so sync always describes the counts presented with it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hcount <= '0;
			vcount <= '0;
			sync   <= SYNC_IDLE;
		end else begin
			hcount     <= h_next;
			vcount     <= v_next;
			// active low sync pulses
			sync.hsync <= !((h_next >= H_SYNC_START) && (h_next < H_SYNC_END));
			sync.vsync <= !((v_next >= V_SYNC_START) && (v_next < V_SYNC_END));
			// blank outside the visible rectangle
			sync.blank <= (h_next >= H_VISIBLE) || (v_next >= V_VISIBLE);
		end
	end

endmodule

//--- source/target_mark.sv
`timescale 1ns/1ps

module target_mark import radar_pkg::*; #(
	parameter color_t GRID_COLOR   = 24'hFF_00_00,
	parameter color_t BLANK_COLOR  = 24'h00_00_00,
	parameter color_t TARGET_COLOR = 24'h00_FF_00,
	parameter int     TARGET_HALF  = 2
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       target_load,
	input  logic       target_clear,
	input  coord_t     target_x,
	input  coord_t     target_y,
	input  grid_px_t   px_in,
	output video_out_t video
);

	// marker reaches this far from its centre on each axis
	localparam dist_t MARK_HALF = dist_t'(TARGET_HALF);

	logic   tgt_en;
	coord_t tgt_x;
	coord_t tgt_y;

	////////////////////////////////////////////////////////////
	// target state
	////////////////////////////////////////////////////////////

	// load has priority over clear
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tgt_en <= 1'b0;
		end else if (target_load) begin
			tgt_en <= 1'b1;
		end else if (target_clear) begin
			tgt_en <= 1'b0;
		end
	end

	// position only matters while enabled
	always_ff @(posedge clk) begin
		if (target_load) begin
			tgt_x <= target_x;
			tgt_y <= target_y;
		end
	end

	////////////////////////////////////////////////////////////
	// colour select
	////////////////////////////////////////////////////////////

	dist_t  dx;
	dist_t  dy;
	logic   on_target;
	color_t pixel_d;

	always_comb begin
		// widen before subtracting so far pixels cannot wrap into the box
		dx = dist_t'(px_in.x) - dist_t'(tgt_x);
		dy = dist_t'(px_in.y) - dist_t'(tgt_y);
		on_target = tgt_en &&
			(dx >= -MARK_HALF) && (dx <= MARK_HALF) &&
			(dy >= -MARK_HALF) && (dy <= MARK_HALF);

		// blank, then target, then grid
		if (px_in.sync.blank) begin
			pixel_d = BLANK_COLOR;
		end else if (on_target) begin
			pixel_d = TARGET_COLOR;
		end else if (px_in.on_grid) begin
			pixel_d = GRID_COLOR;
		end else begin
			pixel_d = BLANK_COLOR;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			video <= '{sync: SYNC_IDLE, pixel: BLANK_COLOR};
		end else begin
			video <= '{sync: px_in.sync, pixel: pixel_d};
		end
	end

endmodule

//--- verif/radar_display_sva.sv
`timescale 1ns/1ps

module radar_display_sva import radar_pkg::*; #(
	parameter int     H_SYNC      = 96,
	parameter color_t BLANK_COLOR = 24'h00_00_00
) (
	input logic       clk,
	input logic       arst_n,
	input video_out_t video
);

	// sync pulse is low for H_SYNC cycles, high again just before it
	property hsync_width_p;
		@(posedge clk) disable iff (!arst_n)
		$rose(video.sync.hsync) |->
			!$past(video.sync.hsync, H_SYNC) && $past(video.sync.hsync, H_SYNC + 1);
	endproperty

	// vertical sync only ever falls inside blanking
	property vsync_blank_p;
		@(posedge clk) disable iff (!arst_n)
		!video.sync.vsync |-> video.sync.blank;
	endproperty

	// nothing is painted while blanked
	property blank_color_p;
		@(posedge clk) disable iff (!arst_n)
		video.sync.blank |-> (video.pixel == BLANK_COLOR);
	endproperty

	assert property (hsync_width_p) else $error("hsync low width is not %0d cycles", H_SYNC);
	assert property (vsync_blank_p) else $error("vsync low outside blanking");
	assert property (blank_color_p) else $error("pixel not blank colour during blank");

endmodule

// attach to every instance of the top level
bind radar_display_top radar_display_sva #(
	.H_SYNC(H_SYNC), .BLANK_COLOR(BLANK_COLOR)
) radar_display_sva_inst (.clk(clk), .arst_n(arst_n), .video(video));

//--- verif/radar_display_tb.sv
`timescale 1ns/1ps

module radar_display_tb import radar_pkg::*; ();

	////////////////////////////////////////////////////////////
	// small raster and grid geometry
	////////////////////////////////////////////////////////////

	localparam int H_ACTIVE = 320;
	localparam int H_FRONT  = 8;
	localparam int H_SYNC   = 2;
	localparam int H_BACK   = 16;
	localparam int V_ACTIVE = 240;
	localparam int V_FRONT  = 8;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 16;
	localparam int LINE_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int FRAME_TOTAL = LINE_TOTAL * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
	// partial frame after reset plus frames 1 to 3 fit in four totals
	localparam int TIMEOUT_CYCLES = 4 * FRAME_TOTAL + 100;

	localparam int LEFT_BORDER   = -96;
	localparam int RIGHT_BORDER  = 96;
	localparam int TOP_BORDER    = 230;
	localparam int BOTTOM_BORDER = 16;
	localparam int LINE_WIDTH    = 1;
	localparam int TARGET_HALF   = 2;
	localparam int MARK_AREA     = (2 * TARGET_HALF + 1) * (2 * TARGET_HALF + 1);
	localparam color_t GRID_COLOR   = 24'hFF_00_00;
	localparam color_t BLANK_COLOR  = 24'h00_00_00;
	localparam color_t TARGET_COLOR = 24'h00_FF_00;
	localparam video_sync_t IDLE_SYNC = '{hsync: 1'b1, vsync: 1'b1, blank: 1'b1};
	localparam logic [31:0] SEED = 32'h3621cc4b;

	logic       clk;
	logic       arst_n;
	logic       target_load;
	logic       target_clear;
	coord_t     target_x;
	coord_t     target_y;
	video_out_t video;

	tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) tb_clock_gen_inst (
		.clk(clk), .arst_n(arst_n)
	);

	radar_display_top #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
		.LEFT_BORDER(LEFT_BORDER), .RIGHT_BORDER(RIGHT_BORDER),
		.TOP_BORDER(TOP_BORDER), .BOTTOM_BORDER(BOTTOM_BORDER), .LINE_WIDTH(LINE_WIDTH),
		.GRID_COLOR(GRID_COLOR), .BLANK_COLOR(BLANK_COLOR),
		.TARGET_COLOR(TARGET_COLOR), .TARGET_HALF(TARGET_HALF)
	) radar_display_top_inst (
		.clk(clk), .arst_n(arst_n), .target_load(target_load), .target_clear(target_clear),
		.target_x(target_x), .target_y(target_y), .video(video)
	);

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	function automatic int abs_of(input int v);
		return (v < 0) ? -v : v;
	endfunction

	// colour of an active pixel at display position x, y
	function automatic color_t expected_pixel(input int x, input int y,
			input logic tgt_en, input int tgt_x, input int tgt_y);
		int   yr;
		int   d2;
		int   r;
		int   tol;
		int   t15;
		int   t75;
		logic hit;
		logic outside;
		// marker sits on top of everything else
		if (tgt_en && abs_of(x - tgt_x) <= TARGET_HALF && abs_of(y - tgt_y) <= TARGET_HALF) begin
			return TARGET_COLOR;
		end
		// frame band is 3 pixels wide beyond each border line
		outside = (x > RIGHT_BORDER + 3) || (x < LEFT_BORDER - 3) ||
			(y > TOP_BORDER + 3) || (y < BOTTOM_BORDER - 3);
		hit = (x >= RIGHT_BORDER) || (x <= LEFT_BORDER) ||
			(y >= TOP_BORDER) || (y <= BOTTOM_BORDER);
		// range arcs around the origin on the bottom border
		yr = y - BOTTOM_BORDER;
		d2 = x * x + yr * yr;
		for (int k = 1; k <= 7; k++) begin
			r   = 32 * k;
			tol = (r < 64) ? 64 : ((r <= 128) ? 128 : 256);
			if (abs_of(d2 - r * r) <= tol * LINE_WIDTH) begin
				hit = 1'b1;
			end
		end
		// radial line slopes in 64ths rounded toward minus infinity
		t15 = (x * 17) >>> 6;
		t75 = (x * 240) >>> 6;
		if (abs_of(t15 - yr) <= LINE_WIDTH || abs_of(t15 + yr) <= LINE_WIDTH ||
				abs_of(x - yr) <= LINE_WIDTH || abs_of(x + yr) <= LINE_WIDTH ||
				abs_of(t75 - yr) <= 3 * LINE_WIDTH || abs_of(t75 + yr) <= 3 * LINE_WIDTH) begin
			hit = 1'b1;
		end
		return (hit && !outside) ? GRID_COLOR : BLANK_COLOR;
	endfunction

	////////////////////////////////////////////////////////////
	// compare tasks and error counts
	////////////////////////////////////////////////////////////

	int color_errors = 0;
	int sync_errors  = 0;
	int count_errors = 0;
	int other_errors = 0;

	task automatic compare_color(input string name, input color_t expected, input color_t actual);
		if (actual !== expected) begin
			color_errors++;
			$display("error %s: expected %06h, actual %06h", name, expected, actual);
		end
	endtask

	task automatic compare_sync(input string name, input video_sync_t expected,
			input video_sync_t actual);
		if (actual !== expected) begin
			sync_errors++;
			$display("error %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic compare_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			count_errors++;
			$display("error %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	function automatic int total_errors();
		return color_errors + sync_errors + count_errors + other_errors;
	endfunction

	task automatic report_counts();
		$display("errors: color %0d, sync %0d, count %0d, other %0d",
			color_errors, sync_errors, count_errors, other_errors);
	endtask

	////////////////////////////////////////////////////////////
	// checker that follows the raster from the output sync alone
	////////////////////////////////////////////////////////////

	int   col = 0;
	int   row = 0;
	int   frame_num = 0;
	int   line_cycles = 0;
	int   hs_low_cycles = 0;
	int   target_pixels = 0;
	logic have_line = 1'b0;
	logic prev_hsync = 1'b1;
	logic prev_vsync = 1'b1;
	// target state as the stimulus last set it
	logic ref_en = 1'b0;
	int   ref_x = 0;
	int   ref_y = 0;

	always @(negedge clk) begin
		if (arst_n) begin
			line_cycles++;
			if (!video.sync.blank) begin
				if (frame_num >= 1 && (row >= V_ACTIVE || col >= H_ACTIVE)) begin
					other_errors++;
					$display("active pixel outside the visible area at row %0d, column %0d", row, col);
				end else if (frame_num >= 1) begin
					compare_color($sformatf("frame %0d pixel (%0d,%0d)", frame_num,
						col - H_ACTIVE / 2, V_ACTIVE - 1 - row),
						expected_pixel(col - H_ACTIVE / 2, V_ACTIVE - 1 - row, ref_en, ref_x, ref_y),
						video.pixel);
				end
				if (video.pixel == TARGET_COLOR) begin
					target_pixels++;
				end
				col++;
			end
			if (!video.sync.hsync) begin
				hs_low_cycles++;
			end
			// falling hsync marks a line end
			if (prev_hsync && !video.sync.hsync) begin
				if (frame_num >= 1 && have_line) begin
					compare_count("line total", LINE_TOTAL, line_cycles);
				end
				if (col != 0) begin
					if (frame_num >= 1) begin
						compare_count("active pixels per line", H_ACTIVE, col);
					end
					row++;
				end
				have_line   = 1'b1;
				line_cycles = 0;
				col         = 0;
			end
			if (!prev_hsync && video.sync.hsync) begin
				if (frame_num >= 1) begin
					compare_count("hsync width", H_SYNC, hs_low_cycles);
				end
				hs_low_cycles = 0;
			end
			// falling vsync marks a frame end
			if (prev_vsync && !video.sync.vsync) begin
				if (frame_num >= 1) begin
					compare_count($sformatf("active lines in frame %0d", frame_num), V_ACTIVE, row);
					compare_count($sformatf("marker pixels in frame %0d", frame_num),
						(frame_num == 2) ? MARK_AREA : 0, target_pixels);
				end
				frame_num++;
				row           = 0;
				target_pixels = 0;
			end
			prev_hsync = video.sync.hsync;
			prev_vsync = video.sync.vsync;
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	initial begin
		int pick_x;
		int pick_y;
		target_load  = 1'b0;
		target_clear = 1'b0;
		target_x     = '0;
		target_y     = '0;
		void'($urandom(SEED));
		// output idle while reset is held
		@(posedge clk);
		@(negedge clk);
		compare_sync("sync during reset", IDLE_SYNC, video.sync);
		compare_color("pixel during reset", BLANK_COLOR, video.pixel);
		// still idle while the pipeline fills
		@(posedge arst_n);
		@(negedge clk);
		compare_sync("sync after reset", IDLE_SYNC, video.sync);
		compare_color("pixel after reset", BLANK_COLOR, video.pixel);
		// frame 1 is grid only
		// load in the blanking before frame 2
		wait (frame_num == 2);
		@(negedge clk);
		pick_x = LEFT_BORDER + TARGET_HALF + 1 +
			int'($urandom % (RIGHT_BORDER - LEFT_BORDER - 2 * TARGET_HALF - 1));
		pick_y = BOTTOM_BORDER + TARGET_HALF + 1 +
			int'($urandom % (TOP_BORDER - BOTTOM_BORDER - 2 * TARGET_HALF - 1));
		target_x    = coord_t'(pick_x);
		target_y    = coord_t'(pick_y);
		target_load = 1'b1;
		ref_x       = pick_x;
		ref_y       = pick_y;
		ref_en      = 1'b1;
		@(negedge clk);
		target_load = 1'b0;
		$display("target loaded at (%0d,%0d)", pick_x, pick_y);
		// remove the marker before frame 3
		wait (frame_num == 3);
		@(negedge clk);
		target_clear = 1'b1;
		ref_en       = 1'b0;
		@(negedge clk);
		target_clear = 1'b0;
		wait (frame_num == 4);
		@(negedge clk);
		report_counts();
		if (total_errors() == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog
	int cycles = 0;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, frame 3 never finished", cycles);
			report_counts();
			$display("Simulation failed");
			$finish;
		end
	end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic arst_n
);

	// free running clock, low for the first half period
	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2);
			clk = ~clk;
		end
	end

	// reset held over the first rising edges, released on a falling edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule
